// ==== common/shop_pkg.sv ====
package shop_pkg;

	//============================================================
	// widths
	//============================================================
	localparam int DATA_W = 16;
	localparam int MONEY_W = 16;
	localparam int COUNT_W = 4;
	localparam int COUNT_MAX = 15;
	localparam int INFO_W = 64;

	//============================================================
	// encodings
	//============================================================
	typedef enum logic [3:0]
	{
		no_action = 4'd0,
		buy = 4'd1,
		deposit = 4'd4,
		check = 4'd8
	} action_e;

	typedef enum logic [3:0]
	{
		no_err = 4'd0,
		already_have_pkm = 4'd1,
		out_of_money = 4'd2,
		bag_is_full = 4'd4
	} err_e;

	// one-hot
	typedef enum logic [3:0]
	{
		no_type = 4'd0,
		grass = 4'd1,
		fire = 4'd2,
		water = 4'd4,
		electric = 4'd8
	} pkm_type_e;

	typedef enum logic [3:0]
	{
		none = 4'd0,
		lowest = 4'd1
	} stage_e;

	typedef struct packed
	{
		stage_e stage;
		pkm_type_e pkm_type;
		logic [7:0] hp;
		logic [7:0] atk;
		logic [7:0] exp;
	} pkm_info_t;

	typedef struct packed
	{
		logic [COUNT_W-1:0] berry;
		logic [COUNT_W-1:0] medicine;
		logic [COUNT_W-1:0] candy;
		logic [COUNT_W-1:0] bracer;
		logic [MONEY_W-1:0] money;
	} bag_info_t;

	typedef struct packed
	{
		bag_info_t bag;
		pkm_info_t pkm;
	} player_rec_t;

	// same input word, meaning depends on which strobe came with it
	typedef union packed
	{
		struct packed
		{
			logic [DATA_W-9:0] rsv;
			logic [7:0] id;
		} d_id;
		struct packed
		{
			logic [DATA_W-5:0] rsv;
			action_e act;
		} d_act;
		struct packed
		{
			logic [DATA_W-5:0] rsv;
			logic [3:0] item;
		} d_item;
		struct packed
		{
			logic [DATA_W-5:0] rsv;
			logic [3:0] ptype;
		} d_type;
		logic [DATA_W-1:0] d_money;
	} d_word_u;

	//============================================================
	// prices and base stats
	//============================================================
	// berry, medicine, candy, bracer
	localparam logic [MONEY_W-1:0] ITEM_PRICE [4] = '{16, 128, 300, 64};
	// grass, fire, water, electric
	localparam logic [MONEY_W-1:0] PKM_PRICE [4] = '{100, 90, 110, 120};
	localparam logic [7:0] PKM_BASE_HP [4] = '{128, 119, 125, 122};
	localparam logic [7:0] PKM_BASE_ATK [4] = '{63, 64, 60, 65};

endpackage

// ==== common/shop_req_if.sv ====
`timescale 1ns/1ps

interface shop_req_if #(
	parameter int NUM_PLAYERS = 8
) ();

	localparam int ID_W = (NUM_PLAYERS > 1) ? $clog2(NUM_PLAYERS) : 1;

	logic req_valid;
	logic [ID_W-1:0] player;
	shop_pkg::action_e act;
	logic is_monster;
	shop_pkg::d_word_u operand;

	modport decoder
	(
		output req_valid,
		output player,
		output act,
		output is_monster,
		output operand
	);

	modport executor
	(
		input req_valid,
		input player,
		input act,
		input is_monster,
		input operand
	);

endinterface

// ==== common/player_port_if.sv ====
`timescale 1ns/1ps

interface player_port_if #(
	parameter int NUM_PLAYERS = 8
) ();

	localparam int ID_W = (NUM_PLAYERS > 1) ? $clog2(NUM_PLAYERS) : 1;

	logic [ID_W-1:0] addr;
	logic wr_en;
	shop_pkg::player_rec_t wr_data;
	shop_pkg::player_rec_t rd_data;

	modport store
	(
		input addr,
		input wr_en,
		input wr_data,
		output rd_data
	);

	modport executor
	(
		output addr,
		output wr_en,
		output wr_data,
		input rd_data
	);

endinterface

// ==== verilog/command_decoder.sv ====
`timescale 1ns/1ps

module command_decoder #(
	parameter int NUM_PLAYERS = 8
) (
	input logic clk,
	input logic rst_n,
	input logic id_valid,
	input logic act_valid,
	input logic item_valid,
	input logic type_valid,
	input logic amnt_valid,
	input shop_pkg::d_word_u d,
	shop_req_if.decoder req
);

	localparam int ID_W = (NUM_PLAYERS > 1) ? $clog2(NUM_PLAYERS) : 1;

	logic final_strobe;

	// check has no operand, so its action strobe closes the command
	assign final_strobe = item_valid || type_valid || amnt_valid ||
		(act_valid && d.d_act.act == shop_pkg::check);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			req.req_valid <= 1'b0;
			req.player <= '0;
			req.act <= shop_pkg::no_action;
			req.is_monster <= 1'b0;
		end
		else
		begin
			req.req_valid <= final_strobe;
			if (id_valid)
			begin
				req.player <= d.d_id.id[ID_W-1:0];
			end
			// pending action, held until the next act strobe
			if (act_valid)
			begin
				req.act <= d.d_act.act;
			end
			if (final_strobe)
			begin
				req.is_monster <= type_valid;
			end
		end
	end

	// operand word of the last strobe
	always_ff @(posedge clk)
	begin
		if (final_strobe)
		begin
			req.operand <= d;
		end
	end

endmodule

// ==== verilog/player_store.sv ====
`timescale 1ns/1ps

module player_store #(
	parameter int NUM_PLAYERS = 8
) (
	input logic clk,
	input logic rst_n,
	player_port_if.store port
);

	shop_pkg::player_rec_t recs [NUM_PLAYERS];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_PLAYERS; i++)
			begin
				recs[i] <= '0;
			end
		end
		else if (port.wr_en)
		begin
			recs[port.addr] <= port.wr_data;
		end
	end

	// read path is combinational
	assign port.rd_data = recs[port.addr];

	// id comes from the input word through the decoder
	a_wr_addr_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		port.wr_en |-> (port.addr < NUM_PLAYERS)
	);

endmodule

// ==== verilog/shop_executor.sv ====
`timescale 1ns/1ps

module shop_executor #(
	parameter int NUM_PLAYERS = 8
) (
	input logic clk,
	input logic rst_n,
	shop_req_if.executor req,
	player_port_if.executor port,
	output logic out_valid,
	output logic complete,
	output shop_pkg::err_e err_msg,
	output shop_pkg::player_rec_t out_info
);

	localparam int ID_W = (NUM_PLAYERS > 1) ? $clog2(NUM_PLAYERS) : 1;

	logic busy;
	logic [ID_W-1:0] player_q;
	shop_pkg::player_rec_t rec_q;
	shop_pkg::player_rec_t rec_nxt;
	shop_pkg::err_e err_nxt;
	logic [3:0] sel;
	logic [1:0] idx;
	logic [shop_pkg::MONEY_W-1:0] price;
	logic [3:0][shop_pkg::COUNT_W-1:0] cnt;

	function automatic logic [1:0] lowest_set(input logic [3:0] v);
		logic [1:0] pos;
		pos = 2'd0;
		for (int i = 3; i >= 0; i--)
		begin
			if (v[i])
				pos = i[1:0];
		end
		return pos;
	endfunction

	//============================================================
	// apply step
	//============================================================
	// decoder holds act and operand until the next command
	always_comb
	begin
		sel = req.is_monster ? req.operand.d_type.ptype : req.operand.d_item.item;
		idx = lowest_set(sel);
		price = req.is_monster ? shop_pkg::PKM_PRICE[idx] : shop_pkg::ITEM_PRICE[idx];
		cnt = {rec_q.bag.bracer, rec_q.bag.candy, rec_q.bag.medicine, rec_q.bag.berry};
		rec_nxt = rec_q;
		err_nxt = shop_pkg::no_err;
		case (req.act)
			shop_pkg::deposit:
				rec_nxt.bag.money = rec_q.bag.money + req.operand.d_money;
			shop_pkg::buy:
			begin
				if (sel == 4'd0 || price > rec_q.bag.money)
					err_nxt = shop_pkg::out_of_money;
				else if (req.is_monster)
				begin
					if (rec_q.pkm.pkm_type != shop_pkg::no_type)
						err_nxt = shop_pkg::already_have_pkm;
					else
					begin
						rec_nxt.bag.money = rec_q.bag.money - price;
						rec_nxt.pkm.stage = shop_pkg::lowest;
						rec_nxt.pkm.pkm_type = shop_pkg::pkm_type_e'(4'b0001 << idx);
						rec_nxt.pkm.hp = shop_pkg::PKM_BASE_HP[idx];
						rec_nxt.pkm.atk = shop_pkg::PKM_BASE_ATK[idx];
						rec_nxt.pkm.exp = 8'd0;
					end
				end
				else if (cnt[idx] == shop_pkg::COUNT_MAX)
					err_nxt = shop_pkg::bag_is_full;
				else
				begin
					cnt[idx] = cnt[idx] + 1'b1;
					rec_nxt.bag.money = rec_q.bag.money - price;
					{rec_nxt.bag.bracer, rec_nxt.bag.candy,
						rec_nxt.bag.medicine, rec_nxt.bag.berry} = cnt;
				end
			end
			// check leaves the record as is
			default:
				rec_nxt = rec_q;
		endcase
	end

	assign port.addr = busy ? player_q : req.player;
	assign port.wr_en = busy;
	assign port.wr_data = rec_nxt;

	//============================================================
	// load step and result
	//============================================================
	always_ff @(posedge clk)
	begin
		if (req.req_valid)
		begin
			rec_q <= port.rd_data;
			player_q <= req.player;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			out_valid <= 1'b0;
			complete <= 1'b0;
			err_msg <= shop_pkg::no_err;
			out_info <= '0;
		end
		else
		begin
			busy <= req.req_valid;
			out_valid <= busy;
			complete <= busy && (err_nxt == shop_pkg::no_err);
			err_msg <= busy ? err_nxt : shop_pkg::no_err;
			out_info <= (busy && err_nxt == shop_pkg::no_err) ?
				rec_nxt : shop_pkg::player_rec_t'('0);
		end
	end

	// no new command while one is in flight
	a_no_req_busy: assert property (
		@(posedge clk) disable iff (!rst_n)
		busy |-> !req.req_valid
	);

	a_out_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid |=> !out_valid
	);

endmodule

// ==== verilog/pokemon_shop_top.sv ====
`timescale 1ns/1ps

module pokemon_shop_top #(
	parameter int NUM_PLAYERS = 8
) (
	input logic clk,
	input logic rst_n,
	input logic id_valid,
	input logic act_valid,
	input logic item_valid,
	input logic type_valid,
	input logic amnt_valid,
	input logic [shop_pkg::DATA_W-1:0] d,
	output logic out_valid,
	output logic complete,
	output logic [3:0] err_msg,
	output logic [shop_pkg::INFO_W-1:0] out_info
);

	shop_req_if #(.NUM_PLAYERS(NUM_PLAYERS)) req_if ();
	player_port_if #(.NUM_PLAYERS(NUM_PLAYERS)) port_if ();

	command_decoder #(.NUM_PLAYERS(NUM_PLAYERS)) command_decoder_i (
		.clk(clk),
		.rst_n(rst_n),
		.id_valid(id_valid),
		.act_valid(act_valid),
		.item_valid(item_valid),
		.type_valid(type_valid),
		.amnt_valid(amnt_valid),
		.d(shop_pkg::d_word_u'(d)),
		.req(req_if.decoder)
	);

	player_store #(.NUM_PLAYERS(NUM_PLAYERS)) player_store_i (
		.clk(clk),
		.rst_n(rst_n),
		.port(port_if.store)
	);

	shop_executor #(.NUM_PLAYERS(NUM_PLAYERS)) shop_executor_i (
		.clk(clk),
		.rst_n(rst_n),
		.req(req_if.executor),
		.port(port_if.executor),
		.out_valid(out_valid),
		.complete(complete),
		.err_msg(err_msg),
		.out_info(out_info)
	);

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD = 20.0
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
	end

	always #(PERIOD / 2.0) clk = ~clk;

endmodule

// ==== verification/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

	// worst case command count over all six tests
	localparam int NUM_CMDS = 110;
	localparam int CYCLE_LIMIT = 40 * NUM_CMDS + 200;
	localparam int STB_ID = 0;
	localparam int STB_ACT = 1;
	localparam int STB_ITEM = 2;
	localparam int STB_TYPE = 3;
	localparam int STB_AMNT = 4;

	// berry, medicine, candy, bracer
	localparam logic [15:0] item_cost [4] = '{16, 128, 300, 64};
	// grass, fire, water, electric
	localparam logic [15:0] pkm_cost [4] = '{100, 90, 110, 120};
	localparam logic [7:0] base_hp [4] = '{128, 119, 125, 122};
	localparam logic [7:0] base_atk [4] = '{63, 64, 60, 65};

	logic clk;
	logic rst_n;
	logic id_valid;
	logic act_valid;
	logic item_valid;
	logic type_valid;
	logic amnt_valid;
	logic [15:0] d;
	logic out_valid;
	logic complete;
	logic [3:0] err_msg;
	logic [63:0] out_info;

	shop_pkg::player_rec_t model [8];
	logic [2:0] cur_id;
	logic [31:0] lfsr;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int test_errs = 0;
	int cycles = 0;

	tb_clock #(.PERIOD(20.0)) tb_clock_i (.clk(clk));

	pokemon_shop_top #(.NUM_PLAYERS(8)) pokemon_shop_top_i (
		.clk(clk),
		.rst_n(rst_n),
		.id_valid(id_valid),
		.act_valid(act_valid),
		.item_valid(item_valid),
		.type_valid(type_valid),
		.amnt_valid(amnt_valid),
		.d(d),
		.out_valid(out_valid),
		.complete(complete),
		.err_msg(err_msg),
		.out_info(out_info)
	);

	//============================================================
	// helpers
	//============================================================
	// galois lfsr stepped once per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic b;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			b = lfsr[0];
			lfsr = lfsr >> 1;
			if (b)
				lfsr = lfsr ^ 32'h80200003;
			v = {v[30:0], b};
		end
		return v;
	endfunction

	function automatic int lowest_bit_index(input logic [3:0] v);
		int pos;
		pos = 0;
		for (int i = 0; i < 4; i++)
		begin
			if (v[i])
			begin
				pos = i;
				break;
			end
		end
		return pos;
	endfunction

	function automatic logic [3:0] bag_count(input shop_pkg::player_rec_t rec, input int k);
		case (k)
			0: return rec.bag.berry;
			1: return rec.bag.medicine;
			2: return rec.bag.candy;
			default: return rec.bag.bracer;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
		begin
			$display("ERROR %s expected %h got %h", name, expected, actual);
			fail_cnt++;
			test_errs++;
		end
		else
			pass_cnt++;
	endtask

	task automatic model_apply(input logic [2:0] id, input shop_pkg::action_e act,
		input bit is_monster, input logic [15:0] operand, output logic exp_complete,
		output shop_pkg::err_e exp_err, output logic [63:0] exp_info);
		shop_pkg::player_rec_t rec;
		int k;
		rec = model[id];
		exp_err = shop_pkg::no_err;
		k = lowest_bit_index(operand[3:0]);
		if (act == shop_pkg::deposit)
			rec.bag.money = rec.bag.money + operand;
		else if (act == shop_pkg::buy && is_monster)
		begin
			if (pkm_cost[k] > rec.bag.money)
				exp_err = shop_pkg::out_of_money;
			else if (rec.pkm.pkm_type != shop_pkg::no_type)
				exp_err = shop_pkg::already_have_pkm;
			else
			begin
				rec.bag.money = rec.bag.money - pkm_cost[k];
				rec.pkm.stage = shop_pkg::lowest;
				rec.pkm.pkm_type = shop_pkg::pkm_type_e'(4'b0001 << k);
				rec.pkm.hp = base_hp[k];
				rec.pkm.atk = base_atk[k];
				rec.pkm.exp = 8'd0;
			end
		end
		else if (act == shop_pkg::buy)
		begin
			if (item_cost[k] > rec.bag.money)
				exp_err = shop_pkg::out_of_money;
			else if (bag_count(rec, k) == 4'd15)
				exp_err = shop_pkg::bag_is_full;
			else
			begin
				rec.bag.money = rec.bag.money - item_cost[k];
				case (k)
					0: rec.bag.berry = rec.bag.berry + 4'd1;
					1: rec.bag.medicine = rec.bag.medicine + 4'd1;
					2: rec.bag.candy = rec.bag.candy + 4'd1;
					default: rec.bag.bracer = rec.bag.bracer + 4'd1;
				endcase
			end
		end
		if (exp_err == shop_pkg::no_err)
		begin
			model[id] = rec;
			exp_complete = 1'b1;
			exp_info = rec;
		end
		else
		begin
			exp_complete = 1'b0;
			exp_info = '0;
		end
	endtask

	// called on a falling edge and returns on the next one
	task automatic drive_strobe(input int which, input logic [15:0] word);
		d = word;
		case (which)
			STB_ID: id_valid = 1'b1;
			STB_ACT: act_valid = 1'b1;
			STB_ITEM: item_valid = 1'b1;
			STB_TYPE: type_valid = 1'b1;
			default: amnt_valid = 1'b1;
		endcase
		@(negedge clk);
		id_valid = 1'b0;
		act_valid = 1'b0;
		item_valid = 1'b0;
		type_valid = 1'b0;
		amnt_valid = 1'b0;
	endtask

	task automatic do_command(input bit send_id, input logic [2:0] id,
		input shop_pkg::action_e act, input bit is_monster, input logic [15:0] operand);
		logic exp_complete;
		shop_pkg::err_e exp_err;
		logic [63:0] exp_info;
		int waits;
		if (send_id)
		begin
			drive_strobe(STB_ID, {13'd0, id});
			cur_id = id;
		end
		drive_strobe(STB_ACT, {12'd0, act});
		if (act == shop_pkg::buy)
			drive_strobe(is_monster ? STB_TYPE : STB_ITEM, operand);
		else if (act == shop_pkg::deposit)
			drive_strobe(STB_AMNT, operand);
		waits = 0;
		while (!out_valid)
		begin
			@(negedge clk);
			waits++;
		end
		// result is due two cycles after the last strobe was sampled
		if (waits != 2)
		begin
			$display("out_valid came %0d cycles after the last strobe instead of 2", waits);
			fail_cnt++;
			test_errs++;
		end
		else
			pass_cnt++;
		model_apply(cur_id, act, is_monster, operand, exp_complete, exp_err, exp_info);
		check_value("complete", {63'd0, exp_complete}, {63'd0, complete});
		check_value("err_msg", {60'd0, exp_err}, {60'd0, err_msg});
		check_value("out_info", exp_info, out_info);
	endtask

	// deposit that wraps money around to the target
	task automatic set_money(input logic [2:0] id, input logic [15:0] target);
		do_command(1'b1, id, shop_pkg::deposit, 1'b0, target - model[id].bag.money);
	endtask

	task automatic end_test(input int num, input string name);
		$display("test %0d %s: done, %0d errors", num, name, test_errs);
		test_errs = 0;
	endtask

	//============================================================
	// timeout
	//============================================================
	initial
	begin
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: no result after %0d cycles", cycles);
		$display("Test failed");
		$finish;
	end

	//============================================================
	// tests
	//============================================================
	initial
	begin
		logic [2:0] id;
		logic [2:0] base;
		logic [15:0] target;
		int k;
		int n;
		lfsr = 32'h7a51;
		cur_id = '0;
		rst_n = 1'b0;
		id_valid = 1'b0;
		act_valid = 1'b0;
		item_valid = 1'b0;
		type_valid = 1'b0;
		amnt_valid = 1'b0;
		d = '0;
		for (int i = 0; i < 8; i++)
			model[i] = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		for (int i = 0; i < 8; i++)
			do_command(1'b1, 3'(take_bits(3)), shop_pkg::check, 1'b0, 16'd0);
		end_test(1, "check after reset");

		for (int i = 0; i < 8; i++)
		begin
			id = 3'(take_bits(3));
			do_command(1'b1, id, shop_pkg::deposit, 1'b0, 16'(take_bits(16)));
			do_command(1'b0, id, shop_pkg::check, 1'b0, 16'd0);
		end
		end_test(2, "deposit");

		// poor players get less than the cheapest item
		for (int i = 0; i < 12; i++)
		begin
			id = 3'(take_bits(3));
			k = int'(take_bits(2));
			if (take_bits(1) == 32'd1)
				target = 16'(take_bits(4));
			else
				target = item_cost[k] + 16'(take_bits(8));
			set_money(id, target);
			do_command(1'b0, id, shop_pkg::buy, 1'b0, 16'(1 << k));
		end
		end_test(3, "item buy");

		id = 3'(take_bits(3));
		k = int'(take_bits(2));
		set_money(id, 16'd6000);
		n = 16 - int'(bag_count(model[id], k));
		for (int i = 0; i < n; i++)
			do_command(1'b0, id, shop_pkg::buy, 1'b0, 16'(1 << k));
		do_command(1'b0, id, shop_pkg::check, 1'b0, 16'd0);
		end_test(4, "bag full");

		// four distinct players without a monster yet
		base = 3'(take_bits(3));
		for (int i = 0; i < 4; i++)
		begin
			id = base + 3'(i);
			set_money(id, 16'd300);
			do_command(1'b0, id, shop_pkg::buy, 1'b1, 16'(1 << take_bits(2)));
			do_command(1'b0, id, shop_pkg::buy, 1'b1, 16'(1 << take_bits(2)));
			do_command(1'b0, id, shop_pkg::check, 1'b0, 16'd0);
		end
		end_test(5, "monster buy");

		for (int i = 0; i < 20; i++)
		begin
			id = 3'(take_bits(3));
			case (take_bits(2))
				0: do_command(1'b1, id, shop_pkg::deposit, 1'b0, 16'(take_bits(10)));
				1: do_command(1'b1, id, shop_pkg::buy, 1'b0, 16'(1 << take_bits(2)));
				2: do_command(1'b1, id, shop_pkg::buy, 1'b1, 16'(1 << take_bits(2)));
				default: do_command(1'b1, id, shop_pkg::check, 1'b0, 16'd0);
			endcase
		end
		for (int i = 0; i < 8; i++)
			do_command(1'b1, 3'(i), shop_pkg::check, 1'b0, 16'd0);
		end_test(6, "interleaved players");

		$display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== list.f ====
common/shop_pkg.sv
common/shop_req_if.sv
common/player_port_if.sv
verilog/command_decoder.sv
verilog/player_store.sv
verilog/shop_executor.sv
verilog/pokemon_shop_top.sv
verification/tb_clock.sv
verification/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the shop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module tb_top -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0
